// File: mips_pkg.sv
`default_nettype none

package mips_pkg;

	localparam int data_width = 32;
	localparam int reg_addr_bits = 5;

	////////////////////////////////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////////////////////////////////

	// Primary opcodes, instr[31:26]
	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_j     = 6'h02;
	localparam logic [5:0] op_beq   = 6'h04;
	localparam logic [5:0] op_bne   = 6'h05;
	localparam logic [5:0] op_addiu = 6'h09;
	localparam logic [5:0] op_andi  = 6'h0c;
	localparam logic [5:0] op_ori   = 6'h0d;
	localparam logic [5:0] op_lui   = 6'h0f;
	localparam logic [5:0] op_lw    = 6'h23;
	localparam logic [5:0] op_sw    = 6'h2b;

	// R-type function field, instr[5:0]
	localparam logic [5:0] fn_break = 6'h0d;
	localparam logic [5:0] fn_addu  = 6'h21;
	localparam logic [5:0] fn_subu  = 6'h23;
	localparam logic [5:0] fn_and   = 6'h24;
	localparam logic [5:0] fn_or    = 6'h25;
	localparam logic [5:0] fn_slt   = 6'h2a;

	////////////////////////////////////////////////////////////////////
	// Wishbone classic
	////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic                  cyc;
		logic                  stb;
		logic                  we;
		logic [31:0]           adr;
		logic [data_width-1:0] dat;
		logic [3:0]            sel;
	} wb_req_t;

	typedef struct packed {
		logic [data_width-1:0] dat;
		logic                  ack;
	} wb_rsp_t;

	////////////////////////////////////////////////////////////////////
	// Pipeline words
	////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_lui
	} alu_op_e;

	typedef struct packed {
		logic                  valid;
		logic [31:0]           pc;
		logic [data_width-1:0] instr;
	} fetch_t;

	typedef struct packed {
		logic                     valid;
		logic [31:0]              pc;
		alu_op_e                  alu_op;
		logic                     use_imm;
		logic                     is_load;
		logic                     is_store;
		logic                     is_beq;
		logic                     is_bne;
		logic                     is_jump;
		logic                     is_halt;
		logic                     reg_write;
		logic [reg_addr_bits-1:0] dest;
		logic [data_width-1:0]    rs_data;
		logic [data_width-1:0]    rt_data;
		logic [data_width-1:0]    imm;
		logic [31:0]              jump_target;
	} decoded_t;

	typedef struct packed {
		logic                     en;
		logic [reg_addr_bits-1:0] addr;
		logic [data_width-1:0]    data;
	} wb_write_t;

endpackage

`default_nettype wire

// File: instr_fetch.sv
`default_nettype none
`timescale 1ns/100ps

module instr_fetch (
	input  logic              clk,
	input  logic              rst_n,
	output mips_pkg::wb_req_t wb_req,
	input  mips_pkg::wb_rsp_t wb_rsp,
	input  logic              take,
	input  logic              redirect,
	input  logic [31:0]       redirect_pc,
	input  logic              halted,
	output mips_pkg::fetch_t  fetch
);

	import mips_pkg::*;

	logic        busy;
	logic        stale;
	logic        ack;
	logic        start;
	logic [31:0] start_adr;
	logic [31:0] fetch_adr;
	logic [31:0] next_pc;
	logic        buf_valid;
	logic [31:0] buf_pc;
	logic [31:0] buf_instr;

	assign ack = busy && wb_rsp.ack;

	// Next read only when the buffer will have room for it
	assign start = !busy && !halted && (!buf_valid || take || redirect);
	assign start_adr = redirect ? redirect_pc : next_pc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			stale <= 1'b0;
			next_pc <= '0;
			buf_valid <= 1'b0;
		end else begin
			if (start) begin
				busy <= 1'b1;
				next_pc <= start_adr + 32'd4;
			end else if (redirect) begin
				next_pc <= redirect_pc;
			end

			// A read already on the bus has to finish, its word is dropped
			if (ack) begin
				busy <= 1'b0;
				stale <= 1'b0;
			end else if (busy && redirect) begin
				stale <= 1'b1;
			end

			if (redirect)
				buf_valid <= 1'b0;
			else if (ack && !stale)
				buf_valid <= 1'b1;
			else if (take)
				buf_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			fetch_adr <= start_adr;
		if (ack) begin
			buf_pc <= fetch_adr;
			buf_instr <= wb_rsp.dat;
		end
	end

	assign wb_req = '{cyc: busy, stb: busy, we: 1'b0, adr: fetch_adr, dat: '0, sel: 4'hf};
	assign fetch = '{valid: buf_valid, pc: buf_pc, instr: buf_instr};

endmodule

`default_nettype wire

// File: instr_decode.sv
`default_nettype none
`timescale 1ns/100ps

module instr_decode (
	input  logic               clk,
	input  logic               rst_n,
	input  mips_pkg::fetch_t   fetch,
	output logic               take,
	input  logic               retire,
	input  logic               redirect,
	output logic [4:0]         rs_addr,
	output logic [4:0]         rt_addr,
	input  logic [31:0]        rs_data,
	input  logic [31:0]        rt_data,
	output mips_pkg::decoded_t decoded
);

	import mips_pkg::*;

	logic [5:0]  opcode;
	logic [5:0]  funct;
	logic [4:0]  rd;
	logic [15:0] imm16;
	logic [31:0] pc_plus4;
	decoded_t    next_dec;
	decoded_t    dec_q;
	logic        dec_valid;

	// Instruction fields
	assign opcode = fetch.instr[31:26];
	assign rs_addr = fetch.instr[25:21];
	assign rt_addr = fetch.instr[20:16];
	assign rd = fetch.instr[15:11];
	assign funct = fetch.instr[5:0];
	assign imm16 = fetch.instr[15:0];
	assign pc_plus4 = fetch.pc + 32'd4;

	// Issue only into an empty or retiring execute stage
	assign take = fetch.valid && !redirect && (!dec_valid || retire);

	always_comb begin
		next_dec = '0;
		next_dec.valid = 1'b1;
		next_dec.pc = fetch.pc;
		next_dec.alu_op = alu_add;
		next_dec.rs_data = rs_data;
		next_dec.rt_data = rt_data;
		next_dec.imm = {{16{imm16[15]}}, imm16};
		next_dec.jump_target = {pc_plus4[31:28], fetch.instr[25:0], 2'b00};

		case (opcode)
			op_rtype: begin
				next_dec.dest = rd;
				next_dec.reg_write = 1'b1;
				case (funct)
					fn_addu: next_dec.alu_op = alu_add;
					fn_subu: next_dec.alu_op = alu_sub;
					fn_and:  next_dec.alu_op = alu_and;
					fn_or:   next_dec.alu_op = alu_or;
					fn_slt:  next_dec.alu_op = alu_slt;
					fn_break: begin
						next_dec.reg_write = 1'b0;
						next_dec.is_halt = 1'b1;
					end
					// Unknown function codes run as a nop
					default: next_dec.reg_write = 1'b0;
				endcase
			end
			op_addiu, op_andi, op_ori, op_lui, op_lw: begin
				next_dec.use_imm = 1'b1;
				next_dec.reg_write = 1'b1;
				next_dec.dest = rt_addr;
				next_dec.is_load = (opcode == op_lw);
				if (opcode == op_andi || opcode == op_ori || opcode == op_lui)
					next_dec.imm = {16'h0000, imm16};
				if (opcode == op_andi)
					next_dec.alu_op = alu_and;
				else if (opcode == op_ori)
					next_dec.alu_op = alu_or;
				else if (opcode == op_lui)
					next_dec.alu_op = alu_lui;
			end
			op_sw: begin
				next_dec.use_imm = 1'b1;
				next_dec.is_store = 1'b1;
			end
			op_beq:  next_dec.is_beq = 1'b1;
			op_bne:  next_dec.is_bne = 1'b1;
			op_j:    next_dec.is_jump = 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			dec_valid <= 1'b0;
		else if (redirect)
			dec_valid <= 1'b0;
		else if (take)
			dec_valid <= 1'b1;
		else if (retire)
			dec_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (take)
			dec_q <= next_dec;
	end

	always_comb begin
		decoded = dec_q;
		decoded.valid = dec_valid;
	end

endmodule

`default_nettype wire

// File: register_bank.sv
`default_nettype none
`timescale 1ns/100ps

module register_bank (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [4:0]          rs_addr,
	input  logic [4:0]          rt_addr,
	output logic [31:0]         rs_data,
	output logic [31:0]         rt_data,
	input  mips_pkg::wb_write_t wr
);

	import mips_pkg::*;

	logic [data_width-1:0] regs [32];

	// Same-cycle write wins over the stored value
	assign rs_data = (rs_addr == '0) ? '0 :
		(wr.en && wr.addr == rs_addr) ? wr.data : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 :
		(wr.en && wr.addr == rt_addr) ? wr.data : regs[rt_addr];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr.en && wr.addr != '0) begin
			regs[wr.addr] <= wr.data;
		end
	end

endmodule

`default_nettype wire

// File: execute_unit.sv
`default_nettype none
`timescale 1ns/100ps

module execute_unit (
	input  logic                clk,
	input  logic                rst_n,
	input  mips_pkg::decoded_t  decoded,
	output logic                retire,
	output logic                redirect,
	output logic [31:0]         redirect_pc,
	output mips_pkg::wb_write_t wr,
	output logic                mem_start,
	output logic                mem_we,
	output logic [31:0]         mem_addr,
	output logic [31:0]         mem_wdata,
	input  logic                mem_done,
	input  logic [31:0]         mem_rdata,
	output logic                halted
);

	import mips_pkg::*;

	logic [31:0] operand_b;
	logic [31:0] alu_result;
	logic [31:0] branch_target;
	logic        active;
	logic        is_mem;
	logic        branch_taken;
	logic        mem_busy;
	logic        halted_q;

	////////////////////////////////////////////////////////////////////
	// ALU and branch resolution
	////////////////////////////////////////////////////////////////////

	assign operand_b = decoded.use_imm ? decoded.imm : decoded.rt_data;

	always_comb begin
		case (decoded.alu_op)
			alu_add: alu_result = decoded.rs_data + operand_b;
			alu_sub: alu_result = decoded.rs_data - operand_b;
			alu_and: alu_result = decoded.rs_data & operand_b;
			alu_or:  alu_result = decoded.rs_data | operand_b;
			alu_slt: alu_result = {31'b0, $signed(decoded.rs_data) < $signed(operand_b)};
			alu_lui: alu_result = {operand_b[15:0], 16'h0000};
			default: alu_result = '0;
		endcase
	end

	assign branch_taken = (decoded.is_beq && decoded.rs_data == decoded.rt_data) ||
		(decoded.is_bne && decoded.rs_data != decoded.rt_data);
	assign branch_target = decoded.pc + 32'd4 + {decoded.imm[29:0], 2'b00};

	////////////////////////////////////////////////////////////////////
	// Retire and memory handshake
	////////////////////////////////////////////////////////////////////

	// Nothing executes once the core has halted
	assign active = decoded.valid && !halted_q;
	assign is_mem = decoded.is_load || decoded.is_store;
	assign retire = active && (!is_mem || mem_done);

	assign redirect = retire && (branch_taken || decoded.is_jump);
	assign redirect_pc = decoded.is_jump ? decoded.jump_target : branch_target;

	assign mem_start = active && is_mem && !mem_busy;
	assign mem_we = decoded.is_store;
	assign mem_addr = alu_result;
	assign mem_wdata = decoded.rt_data;

	assign wr.en = retire && decoded.reg_write;
	assign wr.addr = decoded.dest;
	assign wr.data = decoded.is_load ? mem_rdata : alu_result;

	assign halted = halted_q || (retire && decoded.is_halt);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_busy <= 1'b0;
			halted_q <= 1'b0;
		end else begin
			if (mem_start)
				mem_busy <= 1'b1;
			else if (mem_done)
				mem_busy <= 1'b0;
			if (retire && decoded.is_halt)
				halted_q <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: data_access.sv
`default_nettype none
`timescale 1ns/100ps

module data_access (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	input  logic              we,
	input  logic [31:0]       addr,
	input  logic [31:0]       wdata,
	output logic              done,
	output logic [31:0]       rdata,
	output mips_pkg::wb_req_t wb_req,
	input  mips_pkg::wb_rsp_t wb_rsp
);

	import mips_pkg::*;

	logic        busy;
	logic        ack;
	logic        done_q;
	logic        we_q;
	logic [31:0] adr_q;
	logic [31:0] dat_q;
	logic [31:0] rdata_q;

	assign ack = busy && wb_rsp.ack;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= ack;
			if (start)
				busy <= 1'b1;
			else if (ack)
				busy <= 1'b0;
		end
	end

	// Request held stable for the whole transfer
	always_ff @(posedge clk) begin
		if (start) begin
			we_q <= we;
			adr_q <= addr;
			dat_q <= wdata;
		end
		if (ack)
			rdata_q <= wb_rsp.dat;
	end

	assign wb_req = '{cyc: busy, stb: busy, we: we_q, adr: adr_q, dat: dat_q, sel: 4'hf};
	assign done = done_q;
	assign rdata = rdata_q;

endmodule

`default_nettype wire

// File: bus_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

module bus_arbiter (
	input  logic              clk,
	input  logic              rst_n,
	input  mips_pkg::wb_req_t fetch_req,
	output mips_pkg::wb_rsp_t fetch_rsp,
	input  mips_pkg::wb_req_t data_req,
	output mips_pkg::wb_rsp_t data_rsp,
	output mips_pkg::wb_req_t bus_req,
	input  mips_pkg::wb_rsp_t bus_rsp
);

	import mips_pkg::*;

	logic locked_q;
	logic owner_q;
	logic owner_cyc;
	logic grant_data;

	// 1 selects the data master
	assign owner_cyc = owner_q ? data_req.cyc : fetch_req.cyc;

	always_comb begin
		if (locked_q && owner_cyc)
			grant_data = owner_q;
		else
			grant_data = data_req.cyc;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			locked_q <= 1'b0;
			owner_q <= 1'b0;
		end else begin
			locked_q <= bus_req.cyc;
			owner_q <= grant_data;
		end
	end

	assign bus_req = grant_data ? data_req : fetch_req;

	// Ack goes to the owner only
	assign fetch_rsp.dat = bus_rsp.dat;
	assign fetch_rsp.ack = bus_rsp.ack && !grant_data;
	assign data_rsp.dat = bus_rsp.dat;
	assign data_rsp.ack = bus_rsp.ack && grant_data;

endmodule

`default_nettype wire

// File: mips_core.sv
`default_nettype none
`timescale 1ns/100ps

module mips_core (
	input  logic              clk,
	input  logic              rst_n,
	output mips_pkg::wb_req_t wb_req,
	input  mips_pkg::wb_rsp_t wb_rsp,
	output logic              halted
);

	import mips_pkg::*;

	wb_req_t     fetch_bus_req;
	wb_rsp_t     fetch_bus_rsp;
	wb_req_t     data_bus_req;
	wb_rsp_t     data_bus_rsp;
	fetch_t      fetch_word;
	decoded_t    decoded;
	wb_write_t   wr;
	logic        take;
	logic        retire;
	logic        redirect;
	logic [31:0] redirect_pc;
	logic [4:0]  rs_addr;
	logic [4:0]  rt_addr;
	logic [31:0] rs_data;
	logic [31:0] rt_data;
	logic        mem_start;
	logic        mem_we;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic        mem_done;
	logic [31:0] mem_rdata;

	////////////////////////////////////////////////////////////////////
	// Pipeline stages
	////////////////////////////////////////////////////////////////////

	instr_fetch i_instr_fetch (
		.clk(clk), .rst_n(rst_n), .wb_req(fetch_bus_req), .wb_rsp(fetch_bus_rsp),
		.take(take), .redirect(redirect), .redirect_pc(redirect_pc),
		.halted(halted), .fetch(fetch_word));

	instr_decode i_instr_decode (
		.clk(clk), .rst_n(rst_n), .fetch(fetch_word), .take(take), .retire(retire),
		.redirect(redirect), .rs_addr(rs_addr), .rt_addr(rt_addr),
		.rs_data(rs_data), .rt_data(rt_data), .decoded(decoded));

	register_bank i_register_bank (
		.clk(clk), .rst_n(rst_n), .rs_addr(rs_addr), .rt_addr(rt_addr),
		.rs_data(rs_data), .rt_data(rt_data), .wr(wr));

	execute_unit i_execute_unit (
		.clk(clk), .rst_n(rst_n), .decoded(decoded), .retire(retire),
		.redirect(redirect), .redirect_pc(redirect_pc), .wr(wr),
		.mem_start(mem_start), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_done(mem_done), .mem_rdata(mem_rdata),
		.halted(halted));

	////////////////////////////////////////////////////////////////////
	// Memory side
	////////////////////////////////////////////////////////////////////

	data_access i_data_access (
		.clk(clk), .rst_n(rst_n), .start(mem_start), .we(mem_we), .addr(mem_addr),
		.wdata(mem_wdata), .done(mem_done), .rdata(mem_rdata),
		.wb_req(data_bus_req), .wb_rsp(data_bus_rsp));

	bus_arbiter i_bus_arbiter (
		.clk(clk), .rst_n(rst_n), .fetch_req(fetch_bus_req), .fetch_rsp(fetch_bus_rsp),
		.data_req(data_bus_req), .data_rsp(data_bus_rsp),
		.bus_req(wb_req), .bus_rsp(wb_rsp));

endmodule

`default_nettype wire

// File: tb_mips_core.sv
`default_nettype none
`timescale 1ns/100ps

module tb_mips_core;

	import mips_pkg::*;

	logic        clk;
	logic        rst_n = 1'b0;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp = '0;
	logic        halted;

	logic [31:0] mem [256];
	logic [31:0] exp_adr [$];
	logic [31:0] exp_dat [$];
	int          p_count = 0;
	int          limit = 0;
	int          cycle_count = 0;
	int          store_idx = 0;
	int          wait_left = 0;
	logic        in_transfer = 1'b0;
	logic        first_seen = 1'b0;
	logic        stb_prev = 1'b0;
	logic        halted_prev = 1'b0;
	logic [15:0] lfsr = 16'd91;

	mips_core i_mips_core (
		.clk(clk), .rst_n(rst_n), .wb_req(wb_req), .wb_rsp(wb_rsp), .halted(halted));

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////
	// Reporting and random draws
	////////////////////////////////////////////////////////////////////

	task report_failure(input string reason);
		$display("%s", reason);
		$display("Errors found");
		$fatal(1);
	endtask

	task check_value(input string name, input logic [31:0] actual, input logic [31:0] expected);
		if (actual !== expected)
			report_failure($sformatf("mismatch %s: got %h, expected %h", name, actual, expected));
	endtask

	// Galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		logic [15:0] next;
		next = state >> 1;
		if (state[0])
			next = next ^ 16'hb400;
		return next;
	endfunction

	task draw_wait_states(output int count);
		count = 0;
		repeat (2) begin
			count = count * 2 + lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
	endtask

	////////////////////////////////////////////////////////////////////
	// Cases file and memory image
	////////////////////////////////////////////////////////////////////

	task load_cases();
		int               fd;
		int               n;
		logic [7:0]       tag;
		logic [31:0]      adr;
		logic [31:0]      dat;
		logic [8*200-1:0] line;
		bit               done;
		// Unloaded words decode as an unused opcode
		for (int i = 0; i < 256; i++)
			mem[i] = 32'hfc00_0000 | i;
		done = 1'b0;
		fd = $fopen("program_cases.txt", "r");
		if (fd == 0) begin
			report_failure("cannot open program_cases.txt");
		end else begin
			while (!done) begin
				n = $fscanf(fd, "%s", tag);
				if (n != 1) begin
					done = 1'b1;
				end else if (tag == "#") begin
					n = $fgets(line, fd);
				end else if (tag == "P") begin
					n = $fscanf(fd, "%h %h", adr, dat);
					mem[adr[9:2]] = dat;
					p_count++;
					n = $fgets(line, fd);
				end else if (tag == "S") begin
					n = $fscanf(fd, "%h %h", adr, dat);
					exp_adr.push_back(adr);
					exp_dat.push_back(dat);
					n = $fgets(line, fd);
				end else begin
					report_failure("unknown line tag in program_cases.txt");
				end
			end
			$fclose(fd);
		end
	endtask

	////////////////////////////////////////////////////////////////////
	// Wishbone memory model
	////////////////////////////////////////////////////////////////////

	task accept_request();
		if (wb_req.adr[31:10] != '0) begin
			report_failure($sformatf("bus address %h is outside the memory model", wb_req.adr));
		end else begin
			// Word transfers only
			check_value("wb_req.sel", wb_req.sel, 32'hf);
			if (!first_seen) begin
				check_value("wb_req.adr", wb_req.adr, 32'h0);
				check_value("wb_req.we", wb_req.we, 32'h0);
				first_seen = 1'b1;
			end
			draw_wait_states(wait_left);
			in_transfer = 1'b1;
		end
	endtask

	task answer_request();
		if (wb_req.we) begin
			if (store_idx >= exp_adr.size()) begin
				report_failure($sformatf("unexpected store of %h to %h after the last expected one",
					wb_req.dat, wb_req.adr));
			end else begin
				check_value("wb_req.adr", wb_req.adr, exp_adr[store_idx]);
				check_value("wb_req.dat", wb_req.dat, exp_dat[store_idx]);
				store_idx++;
			end
			mem[wb_req.adr[9:2]] = wb_req.dat;
		end else begin
			wb_rsp.dat <= mem[wb_req.adr[9:2]];
		end
		wb_rsp.ack <= 1'b1;
		in_transfer = 1'b0;
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			wb_rsp <= '0;
			in_transfer = 1'b0;
		end else if (wb_rsp.ack) begin
			// One-cycle ack
			wb_rsp.ack <= 1'b0;
		end else if (wb_req.cyc && wb_req.stb) begin
			if (!in_transfer)
				accept_request();
			if (wait_left > 0)
				wait_left--;
			else
				answer_request();
		end
	end

	// Watchdog and a quiet bus once halted
	always @(posedge clk) begin
		if (rst_n) begin
			cycle_count++;
			if (cycle_count >= limit)
				report_failure($sformatf("timeout: core did not halt within %0d cycles", limit));
			if (halted_prev && wb_req.stb && !stb_prev)
				report_failure("a bus cycle started after the core halted");
			if (halted_prev)
				check_value("halted", halted, 32'h1);
			stb_prev <= wb_req.stb;
			halted_prev <= halted;
		end
	end

	initial begin
		load_cases();
		limit = 60 * (p_count + exp_adr.size());
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check_value("wb_req.cyc", wb_req.cyc, 32'h0);
		check_value("halted", halted, 32'h0);
		while (halted !== 1'b1)
			@(posedge clk);
		// Window for an in-flight fetch to drain
		repeat (20) @(posedge clk);
		if (store_idx != exp_adr.size()) begin
			report_failure($sformatf("only %0d of %0d expected stores were seen",
				store_idx, exp_adr.size()));
		end else begin
			$display("No errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: program_cases.txt
# P <byte address> <instruction word>, program image in hex
# S <byte address> <store data>, expected stores in program order
P 000 240A0200  # addiu $10, $0, 0x200
P 004 24010005  # addiu $1, $0, 5
P 008 2402FFFD  # addiu $2, $0, -3
P 00C 00412023  # subu $4, $2, $1
P 010 3C051234  # lui $5, 0x1234
P 014 34A5ABCD  # ori $5, $5, 0xabcd
P 018 30A6FF0F  # andi $6, $5, 0xff0f
P 01C 00A43824  # and $7, $5, $4
P 020 00E63821  # addu $7, $7, $6
P 024 AD470000  # sw $7, 0($10)
P 028 0041402A  # slt $8, $2, $1
P 02C 00210021  # addu $0, $1, $1
P 030 01004825  # or $9, $8, $0
P 034 AD490004  # sw $9, 4($10)
P 038 8D4B0000  # lw $11, 0($10)
P 03C 256B0001  # addiu $11, $11, 1
P 040 AD4B0008  # sw $11, 8($10)
P 044 10220001  # beq $1, $2, +1 (not taken)
P 048 AD41000C  # sw $1, 12($10)
P 04C 14220001  # bne $1, $2, +1 (taken)
P 050 AD42000C  # sw $2, 12($10) wrong path
P 054 11280001  # beq $9, $8, +1 (taken)
P 058 AD420010  # sw $2, 16($10) wrong path
P 05C 15090001  # bne $8, $9, +1 (not taken)
P 060 AD440010  # sw $4, 16($10)
P 064 0800001C  # j 0x70
P 068 AD420014  # sw $2, 20($10) wrong path
P 06C 0000000D  # break wrong path
P 070 AD450014  # sw $5, 20($10)
P 074 0000000D  # break
P 078 AD410018  # sw $1, 24($10) after break
S 200 123556D5
S 204 00000001
S 208 123556D6
S 20C 00000005
S 210 FFFFFFF8
S 214 1234ABCD

// File: compile.f
mips_pkg.sv
instr_fetch.sv
instr_decode.sv
register_bank.sv
execute_unit.sv
data_access.sv
bus_arbiter.sv
mips_core.sv
tb_mips_core.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - files:
      - mips_pkg.sv
      - instr_fetch.sv
      - instr_decode.sv
      - register_bank.sv
      - execute_unit.sv
      - data_access.sv
      - bus_arbiter.sv
      - mips_core.sv
  - target: test
    files:
      - tb_mips_core.sv
